// File: list.f
logic/tcp_notify_pkg.sv
logic/tcp_notify_split.sv
logic/tcp_session_table.sv
logic/tcp_rx_req_gen.sv
logic/tcp_notify_regs.sv
logic/tcp_notify_top.sv
dv/tcp_notify_tb.sv

// File: Bender.yml
package:
  name: tcp_notify

sources:
  - logic/tcp_notify_pkg.sv
  - logic/tcp_notify_split.sv
  - logic/tcp_session_table.sv
  - logic/tcp_rx_req_gen.sv
  - logic/tcp_notify_regs.sv
  - logic/tcp_notify_top.sv
  - target: test
    files:
      - dv/tcp_notify_tb.sv

// File: dv/tcp_notify_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_notify_tb
    import tcp_notify_pkg::*;
;

    typedef logic [LEN_BITS-1:0] len_q_t[$];

    // notification counts per phase
    // watchdog budget follows from them
    localparam int N_OPEN = 6;
    localparam int N_RX = 10;
    localparam int N_GAP = 20;
    localparam int N_NOTIFY = N_OPEN + 2 * N_RX + 3 + 2 + 1 + N_GAP;
    localparam int TIMEOUT_CYCLES = N_NOTIFY * 64 + 2000;

    logic aclk;
    logic rst;
    logic s_notify_valid;
    logic s_notify_ready;
    tcp_notify_t s_notify_data;
    logic m_rd_req_valid;
    logic m_rd_req_ready;
    logic [SID_BITS-1:0] m_rd_req_sid;
    logic [LEN_BITS-1:0] m_rd_req_len;
    logic reg_wr;
    logic reg_rd;
    logic [REG_ADDR_BITS-1:0] reg_addr;
    logic [REG_DATA_BITS-1:0] reg_wdata;
    logic [REG_DATA_BITS-1:0] reg_rdata;
    logic reg_rvalid;

    integer seed;
    logic gaps_on;

    // model state
    logic [N_SESSIONS-1:0] model_map;
    logic [REG_DATA_BITS-1:0] model_open;
    logic [REG_DATA_BITS-1:0] model_recv;
    logic [REG_DATA_BITS-1:0] model_drop;
    logic [LEN_BITS-1:0] model_chunk;
    logic [SID_BITS-1:0] exp_sid[$];
    logic [LEN_BITS-1:0] exp_len[$];

    tcp_notify_top u_tcp_notify_top (
        .aclk           (aclk),
        .rst            (rst),
        .s_notify_valid (s_notify_valid),
        .s_notify_ready (s_notify_ready),
        .s_notify_data  (s_notify_data),
        .m_rd_req_valid (m_rd_req_valid),
        .m_rd_req_ready (m_rd_req_ready),
        .m_rd_req_sid   (m_rd_req_sid),
        .m_rd_req_len   (m_rd_req_len),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata),
        .reg_rvalid     (reg_rvalid)
    );

    always #5 aclk = ~aclk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    // expected chunks are full max_chunk pieces then the remainder
    function automatic len_q_t ref_chunks(input logic [LEN_BITS-1:0] len,
                                          input logic [LEN_BITS-1:0] chunk);
        len_q_t q;
        logic [LEN_BITS-1:0] rem;
        rem = len;
        while (rem != '0) begin
            if (rem > chunk) begin
                q.push_back(chunk);
                rem = rem - chunk;
            end else begin
                q.push_back(rem);
                rem = '0;
            end
        end
        return q;
    endfunction

    task automatic check_req(input logic [SID_BITS-1:0] want_sid,
                             input logic [SID_BITS-1:0] got_sid,
                             input logic [LEN_BITS-1:0] want_len,
                             input logic [LEN_BITS-1:0] got_len);
        if (got_sid !== want_sid) begin
            abort_run($sformatf("FAIL m_rd_req_sid exp=%h got=%h", want_sid, got_sid));
        end else if (got_len !== want_len) begin
            abort_run($sformatf("FAIL m_rd_req_len exp=%h got=%h", want_len, got_len));
        end
    endtask

    task automatic check_reg(input string name, input logic [REG_DATA_BITS-1:0] want,
                             input logic [REG_DATA_BITS-1:0] got);
        if (got !== want) begin
            abort_run($sformatf("FAIL reg_rdata(%s) exp=%h got=%h", name, want, got));
        end
    endtask

    // all stimulus tasks start and end 1 ns after a rising edge
    task automatic push_notify(input tcp_notify_t word);
        logic took;
        s_notify_valid = 1'b1;
        s_notify_data = word;
        took = 1'b0;
        while (!took) begin
            @(negedge aclk);
            took = s_notify_ready;
            @(posedge aclk);
            #1;
        end
        s_notify_valid = 1'b0;
    endtask

    task automatic send_open(input logic [SID_BITS-1:0] sid);
        tcp_notify_t w;
        w = '0;
        w.opened = 1'b1;
        w.sid = sid;
        w.body.open_v.ip_addr = 32'h0a00_0100 | sid;
        w.body.open_v.port = 16'd40000 + sid;
        model_map[sid] = 1'b1;
        model_open = model_open + 1;
        push_notify(w);
    endtask

    task automatic send_recv(input logic [SID_BITS-1:0] sid,
                             input logic [LEN_BITS-1:0] len);
        tcp_notify_t w;
        len_q_t chunks;
        w = '0;
        w.sid = sid;
        w.body.recv_v.len = len;
        w.body.recv_v.local_port = 16'd8000 + sid;
        // zero length counts nowhere
        if (len != '0) begin
            if (model_map[sid]) begin
                chunks = ref_chunks(len, model_chunk);
                foreach (chunks[i]) begin
                    exp_sid.push_back(sid);
                    exp_len.push_back(chunks[i]);
                end
                model_recv = model_recv + 1;
            end else begin
                model_drop = model_drop + 1;
            end
        end
        push_notify(w);
    endtask

    task automatic write_reg(input logic [REG_ADDR_BITS-1:0] addr,
                             input logic [REG_DATA_BITS-1:0] data);
        reg_wr = 1'b1;
        reg_addr = addr;
        reg_wdata = data;
        @(posedge aclk);
        #1;
        reg_wr = 1'b0;
    endtask

    task automatic read_reg(input logic [REG_ADDR_BITS-1:0] addr,
                            output logic [REG_DATA_BITS-1:0] data);
        reg_rd = 1'b1;
        reg_addr = addr;
        @(posedge aclk);
        #1;
        reg_rd = 1'b0;
        @(negedge aclk);
        if (reg_rvalid !== 1'b1) begin
            abort_run("register read gave no reg_rvalid one cycle after reg_rd");
        end
        data = reg_rdata;
        @(posedge aclk);
        #1;
    endtask

    // zero must leave the limit unchanged
    task automatic set_chunk(input logic [LEN_BITS-1:0] val);
        write_reg(ADDR_MAX_CHUNK, REG_DATA_BITS'(val));
        if (val != '0) begin
            model_chunk = val;
        end
    endtask

    task automatic close_session(input logic [SID_BITS-1:0] sid);
        write_reg(ADDR_CLOSE, REG_DATA_BITS'(sid));
        model_map[sid] = 1'b0;
    endtask

    task automatic check_model_regs;
        logic [REG_DATA_BITS-1:0] d;
        read_reg(ADDR_MAX_CHUNK, d);
        check_reg("max_chunk", REG_DATA_BITS'(model_chunk), d);
        read_reg(ADDR_CNT_OPEN, d);
        check_reg("cnt_open", model_open, d);
        read_reg(ADDR_CNT_RECV, d);
        check_reg("cnt_recv", model_recv, d);
        read_reg(ADDR_CNT_DROP, d);
        check_reg("cnt_drop", model_drop, d);
        read_reg(ADDR_OPEN_MAP, d);
        check_reg("open_map", REG_DATA_BITS'(model_map), d);
    endtask

    // split holds a word one cycle before the idle generator takes it
    task automatic wait_idle;
        repeat (3) @(posedge aclk);
        while (exp_sid.size() != 0 || m_rd_req_valid) begin
            @(negedge aclk);
        end
        @(posedge aclk);
        #1;
    endtask

    // consumer ready at full rate or with random gaps
    always @(posedge aclk) begin
        #1;
        if (gaps_on) begin
            m_rd_req_ready = ($random(seed) & 3) != 0;
        end else begin
            m_rd_req_ready = 1'b1;
        end
    end

    // compare every request transfer against the model queue
    always @(negedge aclk) begin
        if (!rst && m_rd_req_valid && m_rd_req_ready) begin
            if (exp_sid.size() == 0) begin
                abort_run("read request came out with nothing expected");
            end else begin
                check_req(exp_sid.pop_front(), m_rd_req_sid,
                          exp_len.pop_front(), m_rd_req_len);
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge aclk);
        abort_run("timeout: the run did not finish in the cycle budget");
    end

    initial begin
        int i;
        seed = 8;
        aclk = 1'b0;
        rst = 1'b1;
        gaps_on = 1'b0;
        s_notify_valid = 1'b0;
        s_notify_data = '0;
        m_rd_req_ready = 1'b0;
        reg_wr = 1'b0;
        reg_rd = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        model_map = '0;
        model_open = '0;
        model_recv = '0;
        model_drop = '0;
        model_chunk = CHUNK_RST;
        repeat (8) @(posedge aclk);
        #1;
        rst = 1'b0;

        // reset values
        check_model_regs();

        // open a few sessions then send traffic at two chunk limits
        for (i = 0; i < N_OPEN; i++) begin
            send_open(SID_BITS'(i));
        end
        for (i = 0; i < N_RX; i++) begin
            send_recv(SID_BITS'($unsigned($random(seed)) % N_OPEN),
                      LEN_BITS'(1 + $unsigned($random(seed)) % 1000));
        end
        wait_idle();
        set_chunk(16'd100);
        set_chunk(16'd0);
        check_model_regs();
        for (i = 0; i < N_RX; i++) begin
            send_recv(SID_BITS'($unsigned($random(seed)) % N_OPEN),
                      LEN_BITS'(1 + $unsigned($random(seed)) % 1000));
        end
        wait_idle();

        // never-opened sids drop
        // zero length is ignored
        send_recv(4'd12, 16'd300);
        send_recv(4'd13, 16'd1);
        send_recv(4'd14, 16'd999);
        send_recv(4'd1, 16'd0);
        send_recv(4'd13, 16'd0);
        wait_idle();
        check_model_regs();

        // host close while idle
        close_session(4'd2);
        send_recv(4'd2, 16'd50);
        wait_idle();
        check_model_regs();

        // back-pressure on the request stream
        set_chunk(16'd128);
        gaps_on = 1'b1;
        for (i = 0; i < N_GAP; i++) begin
            send_recv(SID_BITS'($unsigned($random(seed)) % N_OPEN),
                      LEN_BITS'(1 + $unsigned($random(seed)) % 1000));
        end
        wait_idle();
        check_model_regs();

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/tcp_notify_top.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_notify_top
    import tcp_notify_pkg::*;
(
    input  logic                     aclk,
    input  logic                     rst,

    // notifications from the stack
    input  logic                     s_notify_valid,
    output logic                     s_notify_ready,
    input  tcp_notify_t              s_notify_data,

    // chunked read requests
    output logic                     m_rd_req_valid,
    input  logic                     m_rd_req_ready,
    output logic [SID_BITS-1:0]      m_rd_req_sid,
    output logic [LEN_BITS-1:0]      m_rd_req_len,

    // host register port
    input  logic                     reg_wr,
    input  logic                     reg_rd,
    input  logic [REG_ADDR_BITS-1:0] reg_addr,
    input  logic [REG_DATA_BITS-1:0] reg_wdata,
    output logic [REG_DATA_BITS-1:0] reg_rdata,
    output logic                     reg_rvalid
);

    // split outputs
    logic                  open_valid;
    tcp_notify_t           open_data;
    logic                  recv_valid;
    logic                  recv_ready;
    tcp_notify_t           recv_data;

    // table side
    logic [SID_BITS-1:0]   lookup_sid;
    logic                  lookup_hit;
    logic [N_SESSIONS-1:0] open_map;
    logic                  open_event;

    // register side
    logic [LEN_BITS-1:0]   max_chunk;
    logic                  close_strobe;
    logic [SID_BITS-1:0]   close_sid;
    logic                  recv_event;
    logic                  drop_event;

    tcp_notify_split u_split (
        .aclk           (aclk),
        .rst            (rst),
        .s_notify_valid (s_notify_valid),
        .s_notify_ready (s_notify_ready),
        .s_notify_data  (s_notify_data),
        .open_valid     (open_valid),
        .open_data      (open_data),
        .recv_valid     (recv_valid),
        .recv_ready     (recv_ready),
        .recv_data      (recv_data)
    );

    tcp_session_table u_table (
        .aclk         (aclk),
        .rst          (rst),
        .open_valid   (open_valid),
        .open_data    (open_data),
        .close_strobe (close_strobe),
        .close_sid    (close_sid),
        .lookup_sid   (lookup_sid),
        .lookup_hit   (lookup_hit),
        .open_map     (open_map),
        .open_event   (open_event)
    );

    tcp_rx_req_gen u_req_gen (
        .aclk           (aclk),
        .rst            (rst),
        .recv_valid     (recv_valid),
        .recv_ready     (recv_ready),
        .recv_data      (recv_data),
        .lookup_sid     (lookup_sid),
        .lookup_hit     (lookup_hit),
        .max_chunk      (max_chunk),
        .m_rd_req_valid (m_rd_req_valid),
        .m_rd_req_ready (m_rd_req_ready),
        .m_rd_req_sid   (m_rd_req_sid),
        .m_rd_req_len   (m_rd_req_len),
        .recv_event     (recv_event),
        .drop_event     (drop_event)
    );

    tcp_notify_regs u_regs (
        .aclk         (aclk),
        .rst          (rst),
        .reg_wr       (reg_wr),
        .reg_rd       (reg_rd),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .reg_rvalid   (reg_rvalid),
        .max_chunk    (max_chunk),
        .close_strobe (close_strobe),
        .close_sid    (close_sid),
        .open_map     (open_map),
        .open_event   (open_event),
        .recv_event   (recv_event),
        .drop_event   (drop_event)
    );

endmodule

`default_nettype wire

// File: logic/tcp_notify_regs.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_notify_regs
    import tcp_notify_pkg::*;
(
    input  logic                     aclk,
    input  logic                     rst,

    input  logic                     reg_wr,
    input  logic                     reg_rd,
    input  logic [REG_ADDR_BITS-1:0] reg_addr,
    input  logic [REG_DATA_BITS-1:0] reg_wdata,
    output logic [REG_DATA_BITS-1:0] reg_rdata,
    output logic                     reg_rvalid,

    output logic [LEN_BITS-1:0]      max_chunk,

    output logic                     close_strobe,
    output logic [SID_BITS-1:0]      close_sid,

    input  logic [N_SESSIONS-1:0]    open_map,
    input  logic                     open_event,
    input  logic                     recv_event,
    input  logic                     drop_event
);

    logic [REG_DATA_BITS-1:0] cnt_open;
    logic [REG_DATA_BITS-1:0] cnt_recv;
    logic [REG_DATA_BITS-1:0] cnt_drop;
    logic [REG_DATA_BITS-1:0] rd_mux;

    // close takes effect at the strobe edge in the table
    assign close_strobe = reg_wr && (reg_addr == ADDR_CLOSE);
    assign close_sid    = reg_wdata[SID_BITS-1:0];

    always_ff @(posedge aclk) begin
        if (rst) begin
            max_chunk <= CHUNK_RST;
            cnt_open  <= '0;
            cnt_recv  <= '0;
            cnt_drop  <= '0;
        end else begin
            // a zero limit would stall the generator so it is ignored
            if (reg_wr && (reg_addr == ADDR_MAX_CHUNK) &&
                (reg_wdata[LEN_BITS-1:0] != '0)) begin
                max_chunk <= reg_wdata[LEN_BITS-1:0];
            end
            cnt_open <= cnt_open + REG_DATA_BITS'(open_event);
            cnt_recv <= cnt_recv + REG_DATA_BITS'(recv_event);
            cnt_drop <= cnt_drop + REG_DATA_BITS'(drop_event);
        end
    end

    // read decode
    always_comb begin
        case (reg_addr)
            ADDR_MAX_CHUNK: rd_mux = {{(REG_DATA_BITS-LEN_BITS){1'b0}}, max_chunk};
            ADDR_CNT_OPEN:  rd_mux = cnt_open;
            ADDR_CNT_RECV:  rd_mux = cnt_recv;
            ADDR_CNT_DROP:  rd_mux = cnt_drop;
            ADDR_OPEN_MAP:  rd_mux = {{(REG_DATA_BITS-N_SESSIONS){1'b0}}, open_map};
            default:        rd_mux = '0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    // read data one cycle after the strobe
    always_ff @(posedge aclk) begin
        if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

    a_chunk_nonzero: assert property (@(posedge aclk) disable iff (rst)
        max_chunk != '0);

endmodule

`default_nettype wire

// File: logic/tcp_rx_req_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_rx_req_gen
    import tcp_notify_pkg::*;
(
    input  logic                aclk,
    input  logic                rst,

    input  logic                recv_valid,
    output logic                recv_ready,
    input  tcp_notify_t         recv_data,

    output logic [SID_BITS-1:0] lookup_sid,
    input  logic                lookup_hit,

    input  logic [LEN_BITS-1:0] max_chunk,

    output logic                m_rd_req_valid,
    input  logic                m_rd_req_ready,
    output logic [SID_BITS-1:0] m_rd_req_sid,
    output logic [LEN_BITS-1:0] m_rd_req_len,

    output logic                recv_event,
    output logic                drop_event
);

    // high while chunks are being emitted
    logic                emit;
    logic [SID_BITS-1:0] sid_q;
    logic [LEN_BITS-1:0] rem_q;
    logic [LEN_BITS-1:0] chunk_q;
    logic [LEN_BITS-1:0] in_len;
    logic                accept;
    logic                req_fire;
    logic                last_req;

    // length from the receive view
    assign in_len = recv_data.body.recv_v.len;

    assign recv_ready = !emit;
    assign accept     = recv_valid && !emit;
    assign lookup_sid = recv_data.sid;

    // zero length is silently dropped, not counted
    assign recv_event = accept && (in_len != '0) && lookup_hit;
    assign drop_event = accept && (in_len != '0) && !lookup_hit;

    assign m_rd_req_valid = emit;
    assign m_rd_req_sid   = sid_q;
    assign m_rd_req_len   = (rem_q < chunk_q) ? rem_q : chunk_q;
    assign req_fire       = emit && m_rd_req_ready;
    assign last_req       = (rem_q == m_rd_req_len);

    always_ff @(posedge aclk) begin
        if (rst) begin
            emit <= 1'b0;
        end else if (recv_event) begin
            emit <= 1'b1;
        end else if (req_fire && last_req) begin
            emit <= 1'b0;
        end
    end

    // chunk limit latched per notification
    always_ff @(posedge aclk) begin
        if (recv_event) begin
            sid_q   <= recv_data.sid;
            rem_q   <= in_len;
            chunk_q <= max_chunk;
        end else if (req_fire) begin
            rem_q <= rem_q - m_rd_req_len;
        end
    end

    a_req_len: assert property (@(posedge aclk) disable iff (rst)
        m_rd_req_valid |-> (m_rd_req_len != '0));

    a_req_hold: assert property (@(posedge aclk) disable iff (rst)
        m_rd_req_valid && !m_rd_req_ready |=>
            m_rd_req_valid && $stable(m_rd_req_sid) && $stable(m_rd_req_len));

endmodule

`default_nettype wire

// File: logic/tcp_session_table.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_session_table
    import tcp_notify_pkg::*;
(
    input  logic                  aclk,
    input  logic                  rst,

    input  logic                  open_valid,
    input  tcp_notify_t           open_data,

    input  logic                  close_strobe,
    input  logic [SID_BITS-1:0]   close_sid,

    input  logic [SID_BITS-1:0]   lookup_sid,
    output logic                  lookup_hit,

    output logic [N_SESSIONS-1:0] open_map,
    output logic                  open_event
);

    logic [N_SESSIONS-1:0] map_next;

    always_comb begin
        map_next = open_map;
        // close first so a same-cycle open wins
        if (close_strobe) begin
            map_next[close_sid] = 1'b0;
        end
        if (open_valid) begin
            map_next[open_data.sid] = 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            open_map   <= '0;
            open_event <= 1'b0;
        end else begin
            open_map   <= map_next;
            // counted one cycle after the write
            open_event <= open_valid;
        end
    end

    // registered map so new opens show up the cycle after
    assign lookup_hit = open_map[lookup_sid];

endmodule

`default_nettype wire

// File: logic/tcp_notify_split.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_notify_split
    import tcp_notify_pkg::*;
(
    input  logic        aclk,
    input  logic        rst,

    input  logic        s_notify_valid,
    output logic        s_notify_ready,
    input  tcp_notify_t s_notify_data,

    output logic        open_valid,
    output tcp_notify_t open_data,

    output logic        recv_valid,
    input  logic        recv_ready,
    output tcp_notify_t recv_data
);

    logic recv_room;
    logic in_fire;

    // recv slot free when empty or handing off this cycle
    assign recv_room = !recv_valid || recv_ready;

    // table never stalls so opened words always fit
    // only received words see back-pressure
    assign s_notify_ready = s_notify_data.opened ? 1'b1 : recv_room;
    assign in_fire = s_notify_valid && s_notify_ready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            open_valid <= 1'b0;
            recv_valid <= 1'b0;
        end else begin
            // opened slot drains every cycle
            open_valid <= in_fire && s_notify_data.opened;
            if (in_fire && !s_notify_data.opened) begin
                recv_valid <= 1'b1;
            end else if (recv_ready) begin
                recv_valid <= 1'b0;
            end
        end
    end

    // payload capture
    always_ff @(posedge aclk) begin
        if (in_fire && s_notify_data.opened) begin
            open_data <= s_notify_data;
        end
        if (in_fire && !s_notify_data.opened) begin
            recv_data <= s_notify_data;
        end
    end

    // a stalled received word must not change under the generator
    a_recv_hold: assert property (@(posedge aclk) disable iff (rst)
        recv_valid && !recv_ready |=> recv_valid && $stable(recv_data));

endmodule

`default_nettype wire

// File: logic/tcp_notify_pkg.sv
`default_nettype none

package tcp_notify_pkg;

    // session and length widths
    localparam int SID_BITS   = 4;
    localparam int N_SESSIONS = 16;
    localparam int LEN_BITS   = 16;

    // register port
    localparam int REG_ADDR_BITS = 3;
    localparam int REG_DATA_BITS = 32;

    // chunk limit out of reset
    localparam logic [LEN_BITS-1:0] CHUNK_RST = 16'd256;

    // register map
    localparam logic [REG_ADDR_BITS-1:0] ADDR_MAX_CHUNK = 3'd0;
    localparam logic [REG_ADDR_BITS-1:0] ADDR_CLOSE     = 3'd1;
    localparam logic [REG_ADDR_BITS-1:0] ADDR_CNT_OPEN  = 3'd2;
    localparam logic [REG_ADDR_BITS-1:0] ADDR_CNT_RECV  = 3'd3;
    localparam logic [REG_ADDR_BITS-1:0] ADDR_CNT_DROP  = 3'd4;
    localparam logic [REG_ADDR_BITS-1:0] ADDR_OPEN_MAP  = 3'd5;

    // body as seen by a session-opened notification
    typedef struct packed {
        logic [31:0] ip_addr;
        logic [15:0] port;
    } notify_open_t;

    // body as seen by a received-data notification
    typedef struct packed {
        logic [LEN_BITS-1:0] len;
        logic [15:0]         local_port;
        logic [15:0]         rsvd;
    } notify_recv_t;

    // same 48 bits decoded by the opened flag
    typedef union packed {
        notify_open_t open_v;
        notify_recv_t recv_v;
    } notify_body_u;

    typedef struct packed {
        logic                opened;
        logic [SID_BITS-1:0] sid;
        notify_body_u        body;
    } tcp_notify_t;

endpackage

`default_nettype wire
